/* ooo_config.svh */
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

`define XLEN      16
`define AREG_LEN  3
`define AREG_NUM  8
`define PRF_LEN   5
`define PRF_SIZE  32
`define ROB_LEN   3
`define ROB_SIZE  8
`define INSTR_LEN 16

// opcode field, instr[15:13]
`define OP_ADD 3'd0
`define OP_SUB 3'd1
`define OP_AND 3'd2
`define OP_OR  3'd3
`define OP_XOR 3'd4
`define OP_LI  3'd5
`define OP_BNE 3'd6

`endif

/* ooo_pkg.sv */
`include "ooo_config.svh"

package ooo_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`AREG_LEN-1:0]  areg_t;
    typedef logic [`PRF_LEN-1:0]   preg_t;
    typedef logic [`ROB_LEN-1:0]   rob_idx_t;
    typedef logic [2:0]            opcode_t;
    typedef logic [`INSTR_LEN-1:0] instr_t;

    // one rename result, decode to reorder buffer
    typedef struct packed {
        logic  valid;
        areg_t areg;
        preg_t new_preg;
        preg_t prev_preg;
        logic  writes;
        word_t pc;
        word_t imm;     // sign-extended, kept for the branch target
    } alloc_t;

    // free queue slot after this one, slot 0 never used
    function automatic preg_t next_slot(preg_t slot);
        return (slot == preg_t'(`PRF_SIZE - 1)) ? preg_t'(1) : slot + preg_t'(1);
    endfunction

endpackage

/* ooo_ifs.sv */
`timescale 1ns/1ps
`include "ooo_config.svh"

////////////////////////////////////////
// decode to alu
////////////////////////////////////////
interface issue_if import ooo_pkg::*; ();
    logic     valid;
    opcode_t  op;
    preg_t    dest_preg;
    rob_idx_t rob_idx;
    word_t    opa;
    word_t    opb;
    word_t    imm;
    word_t    pc;

    modport src (output valid, op, dest_preg, rob_idx, opa, opb, imm, pc);
    modport dst (input  valid, op, dest_preg, rob_idx, opa, opb, imm, pc);
endinterface

interface cdb_if import ooo_pkg::*; ();
    logic     valid;
    preg_t    dest_preg;    // zero for bne
    rob_idx_t rob_idx;
    word_t    result;
    logic     taken;

    modport src      (output valid, dest_preg, rob_idx, result, taken);
    modport prf_sink (input  valid, dest_preg, result);
    modport rob_sink (input  valid, rob_idx, result, taken);
endinterface

////////////////////////////////////////
// retirement side
////////////////////////////////////////
interface commit_if import ooo_pkg::*; ();
    logic  valid;
    areg_t areg;
    preg_t new_preg;
    preg_t prev_preg;
    logic  writes;
    logic  mis_pred;

    modport src   (output valid, areg, new_preg, prev_preg, writes, mis_pred);
    modport prf   (input  valid, prev_preg, mis_pred);
    modport rrat  (input  valid, areg, new_preg, prev_preg, writes);
    modport flush (input  mis_pred);
endinterface

interface backup_if import ooo_pkg::*; ();
    logic [`PRF_SIZE-1:0]  free;
    logic [`PRF_SIZE-1:0]  valid;
    preg_t [`PRF_SIZE-1:0] queue;
    preg_t                 head;
    preg_t                 tail;
    preg_t [`AREG_NUM-1:0] map;

    modport src      (output free, valid, queue, head, tail, map);
    modport prf      (input  free, valid, queue, head, tail);
    modport map_sink (input  map);
endinterface

/* decode_rename.sv */
`timescale 1ns/1ps
`include "ooo_config.svh"

module decode_rename import ooo_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       instr_valid,
    input  instr_t     instr,
    input  word_t      pc,
    output logic       stall,
    output logic       prf_enable,
    output preg_t      opa_preg_idx,
    output preg_t      opb_preg_idx,
    input  preg_t      prf_free_preg_idx,
    input  logic       free_count_zero,
    input  logic       opa_ready,
    input  word_t      opa_value,
    input  logic       opb_ready,
    input  word_t      opb_value,
    output alloc_t     rob_alloc,
    input  logic       rob_full,
    issue_if.src       issue,
    commit_if.flush    commit,
    backup_if.map_sink backup
);

    preg_t [`AREG_NUM-1:0] map;     // speculative map, entry 0 stays 0
    opcode_t  op;
    areg_t    rd;
    areg_t    rs1;
    areg_t    rs2;
    word_t    imm;
    logic     is_li;
    logic     is_bne;
    logic     writes;
    logic     take;
    rob_idx_t next_rob;             // tracks the reorder buffer tail

    ////////////////////////////////////////
    // fields and lookup
    ////////////////////////////////////////
    assign op     = instr[15:13];
    assign rd     = instr[12:10];
    assign rs1    = instr[9:7];
    assign rs2    = instr[3:1];
    assign imm    = {{(`XLEN - 6){instr[5]}}, instr[5:0]};
    assign is_li  = (op == `OP_LI);
    assign is_bne = (op == `OP_BNE);
    assign writes = !is_bne && (rd != '0);

    // preg 0 is always ready, so unused operands point there
    assign opa_preg_idx = is_li ? '0 : map[rs1];
    assign opb_preg_idx = is_li ? '0 : (is_bne ? map[rd] : map[rs2]);

    assign stall = commit.mis_pred ||
                   (instr_valid && (!opa_ready || !opb_ready || rob_full ||
                                    (writes && free_count_zero)));
    assign take       = instr_valid && !stall;
    assign prf_enable = take && writes;

    always_comb begin
        rob_alloc.valid     = take;
        rob_alloc.areg      = writes ? rd : '0;
        rob_alloc.new_preg  = writes ? prf_free_preg_idx : '0;
        rob_alloc.prev_preg = writes ? map[rd] : '0;
        rob_alloc.writes    = writes;
        rob_alloc.pc        = pc;
        rob_alloc.imm       = imm;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `AREG_NUM; i++) begin
                map[i] <= preg_t'(i);   // arch i starts in preg i
            end
        end else if (commit.mis_pred) begin
            map <= backup.map;
        end else if (prf_enable) begin
            map[rd] <= prf_free_preg_idx;
        end
    end

    ////////////////////////////////////////
    // issue register
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            issue.valid <= 1'b0;
            next_rob    <= '0;
        end else begin
            issue.valid <= take;
            if (commit.mis_pred) begin
                next_rob <= '0;         // buffer empties too
            end else if (take) begin
                next_rob <= next_rob + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            issue.op        <= op;
            issue.dest_preg <= rob_alloc.new_preg;
            issue.rob_idx   <= next_rob;
            issue.opa       <= opa_value;
            issue.opb       <= opb_value;
            issue.imm       <= imm;
            issue.pc        <= pc;
        end
    end

endmodule

/* prf.sv */
`timescale 1ns/1ps
`include "ooo_config.svh"

module prf import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  preg_t     opa_preg_idx,
    input  preg_t     opb_preg_idx,
    input  logic      prf_enable,
    output preg_t     prf_free_preg_idx,
    output logic      opa_ready,
    output word_t     opa_value,
    output logic      opb_ready,
    output word_t     opb_value,
    output logic      free_count_zero,
    cdb_if.prf_sink   cdb,
    commit_if.prf     commit,
    backup_if.prf     backup
);

    word_t [`PRF_SIZE-1:0] prf_values;
    logic  [`PRF_SIZE-1:0] prf_free;
    logic  [`PRF_SIZE-1:0] prf_valid;
    preg_t [`PRF_SIZE-1:0] free_queue;
    preg_t                 queue_head;
    preg_t                 queue_tail;
    logic                  hit_a;
    logic                  hit_b;

    // bus bypass, preg 0 never written by the bus
    assign hit_a = cdb.valid && (cdb.dest_preg != '0) && (opa_preg_idx == cdb.dest_preg);
    assign hit_b = cdb.valid && (cdb.dest_preg != '0) && (opb_preg_idx == cdb.dest_preg);

    assign opa_value = hit_a ? cdb.result : prf_values[opa_preg_idx];
    assign opb_value = hit_b ? cdb.result : prf_values[opb_preg_idx];
    assign opa_ready = hit_a || prf_valid[opa_preg_idx];
    assign opb_ready = hit_b || prf_valid[opb_preg_idx];

    assign prf_free_preg_idx = free_queue[queue_head];
    assign free_count_zero   = ~|prf_free;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `PRF_SIZE; i++) begin
                prf_values[i] <= '0;
                prf_free[i]   <= (i >= `AREG_NUM);  // first pregs hold arch regs
                free_queue[i] <= preg_t'(i);
            end
            prf_valid  <= '1;
            queue_head <= preg_t'(`AREG_NUM);
            queue_tail <= preg_t'(1);
        end else if (commit.mis_pred) begin
            prf_free   <= backup.free;
            prf_valid  <= backup.valid;
            free_queue <= backup.queue;
            queue_head <= backup.head;
            queue_tail <= backup.tail;
        end else begin
            if (commit.valid && commit.prev_preg != '0) begin
                prf_valid[commit.prev_preg] <= 1'b0;   // old mapping released
                prf_free[commit.prev_preg]  <= 1'b1;
                free_queue[queue_tail]      <= commit.prev_preg;
                queue_tail                  <= next_slot(queue_tail);
            end
            if (prf_enable) begin
                prf_free[prf_free_preg_idx]  <= 1'b0;
                prf_valid[prf_free_preg_idx] <= 1'b0;  // not ready until written
                queue_head                   <= next_slot(queue_head);
            end
            if (cdb.valid && cdb.dest_preg != '0) begin
                prf_values[cdb.dest_preg] <= cdb.result;
                prf_valid[cdb.dest_preg]  <= 1'b1;
            end
        end
    end

endmodule

/* alu_execute.sv */
`timescale 1ns/1ps
`include "ooo_config.svh"

module alu_execute import ooo_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    issue_if.dst    issue,
    cdb_if.src      cdb,
    commit_if.flush commit
);

    word_t    result;
    logic     taken;
    logic     s1_valid;
    preg_t    s1_dest;
    rob_idx_t s1_rob;
    word_t    s1_result;
    logic     s1_taken;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (issue.op)
            `OP_ADD: result = issue.opa + issue.opb;
            `OP_SUB: result = issue.opa - issue.opb;
            `OP_AND: result = issue.opa & issue.opb;
            `OP_OR:  result = issue.opa | issue.opb;
            `OP_XOR: result = issue.opa ^ issue.opb;
            `OP_LI:  result = issue.imm;
            `OP_BNE: taken  = (issue.opa != issue.opb);
            default: result = '0;
        endcase
    end

    // valids, both stages dropped on a flush
    always_ff @(posedge clock) begin
        if (reset || commit.mis_pred) begin
            s1_valid  <= 1'b0;
            cdb.valid <= 1'b0;
        end else begin
            s1_valid  <= issue.valid;
            cdb.valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_dest       <= issue.dest_preg;
        s1_rob        <= issue.rob_idx;
        s1_result     <= result;
        s1_taken      <= taken;
        cdb.dest_preg <= s1_dest;   // stage two drives the bus
        cdb.rob_idx   <= s1_rob;
        cdb.result    <= s1_result;
        cdb.taken     <= s1_taken;
    end

endmodule

/* result_commit.sv */
`timescale 1ns/1ps
`include "ooo_config.svh"

module result_commit import ooo_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  alloc_t  rob_alloc,
    output logic    rob_full,
    cdb_if.rob_sink cdb,
    commit_if.src   commit,
    output word_t   commit_value,
    output word_t   commit_pc,
    output logic    redirect,
    output word_t   redirect_pc
);

    alloc_t               entry [`ROB_SIZE];
    word_t                result [`ROB_SIZE];
    logic                 taken [`ROB_SIZE];
    logic [`ROB_SIZE-1:0] done;
    rob_idx_t             head;
    rob_idx_t             tail;
    logic [`ROB_LEN:0]    count;
    logic                 retire;

    assign rob_full = (count == `ROB_SIZE);
    assign retire   = (count != '0) && done[head];

    ////////////////////////////////////////
    // head of buffer
    ////////////////////////////////////////
    assign commit.valid     = retire;
    assign commit.areg      = entry[head].areg;
    assign commit.new_preg  = entry[head].new_preg;
    assign commit.prev_preg = entry[head].prev_preg;
    assign commit.writes    = entry[head].writes;
    assign commit.mis_pred  = retire && taken[head];   // predicted not-taken

    assign commit_value = entry[head].writes ? result[head] : '0;
    assign commit_pc    = entry[head].pc;
    assign redirect     = commit.mis_pred;
    assign redirect_pc  = entry[head].pc + entry[head].imm;

    always_ff @(posedge clock) begin
        if (reset || commit.mis_pred) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (rob_alloc.valid) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb.valid) begin
                done[cdb.rob_idx] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + rob_alloc.valid - retire;
        end
    end

    always_ff @(posedge clock) begin
        if (rob_alloc.valid) begin
            entry[tail] <= rob_alloc;
        end
        if (cdb.valid) begin
            result[cdb.rob_idx] <= cdb.result;
            taken[cdb.rob_idx]  <= cdb.taken;
        end
    end

endmodule

/* retirement_rat.sv */
`timescale 1ns/1ps
`include "ooo_config.svh"

module retirement_rat import ooo_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    commit_if.rrat commit,
    backup_if.src  backup
);

    ////////////////////////////////////////
    // retired copy of rename state
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `AREG_NUM; i++) begin
                backup.map[i] <= preg_t'(i);
            end
            for (int i = 0; i < `PRF_SIZE; i++) begin
                backup.free[i]  <= (i >= `AREG_NUM);
                backup.queue[i] <= preg_t'(i);
            end
            backup.valid <= '1;
            backup.head  <= preg_t'(`AREG_NUM);
            backup.tail  <= preg_t'(1);
        end else if (commit.valid && commit.writes) begin
            backup.map[commit.areg] <= commit.new_preg;

            // dispatch side, replayed at retirement
            backup.free[commit.new_preg]  <= 1'b0;
            backup.valid[commit.new_preg] <= 1'b1;   // it retired, so it was written
            backup.head                   <= next_slot(backup.head);

            // commit side
            backup.free[commit.prev_preg]  <= 1'b1;
            backup.valid[commit.prev_preg] <= 1'b0;
            backup.queue[backup.tail]      <= commit.prev_preg;
            backup.tail                    <= next_slot(backup.tail);
        end
    end

endmodule

/* ooo_top.sv */
`timescale 1ns/1ps
`include "ooo_config.svh"

module ooo_top import ooo_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   instr_valid,
    input  instr_t instr,
    input  word_t  pc,
    output logic   stall,
    output logic   redirect,
    output word_t  redirect_pc,
    output logic   commit_valid,
    output areg_t  commit_areg,
    output word_t  commit_value,
    output word_t  commit_pc
);

    preg_t  opa_preg_idx;
    preg_t  opb_preg_idx;
    preg_t  prf_free_preg_idx;
    logic   prf_enable;
    logic   opa_ready;
    logic   opb_ready;
    word_t  opa_value;
    word_t  opb_value;
    logic   free_count_zero;
    alloc_t rob_alloc;
    logic   rob_full;

    issue_if  issue ();
    cdb_if    cdb ();
    commit_if commit ();
    backup_if backup ();

    assign commit_valid = commit.valid;
    assign commit_areg  = commit.areg;

    decode_rename u_decode (
        .clock, .reset, .instr_valid, .instr, .pc, .stall,
        .prf_enable, .opa_preg_idx, .opb_preg_idx, .prf_free_preg_idx,
        .free_count_zero, .opa_ready, .opa_value, .opb_ready, .opb_value,
        .rob_alloc, .rob_full,
        .issue (issue.src), .commit (commit.flush), .backup (backup.map_sink)
    );

    prf u_prf (
        .clock, .reset, .opa_preg_idx, .opb_preg_idx, .prf_enable,
        .prf_free_preg_idx, .opa_ready, .opa_value, .opb_ready, .opb_value,
        .free_count_zero,
        .cdb (cdb.prf_sink), .commit (commit.prf), .backup (backup.prf)
    );

    alu_execute u_alu (
        .clock, .reset,
        .issue (issue.dst), .cdb (cdb.src), .commit (commit.flush)
    );

    result_commit u_rob (
        .clock, .reset, .rob_alloc, .rob_full,
        .cdb (cdb.rob_sink), .commit (commit.src),
        .commit_value, .commit_pc, .redirect, .redirect_pc
    );

    retirement_rat u_rrat (
        .clock, .reset, .commit (commit.rrat), .backup (backup.src)
    );

endmodule

/* ooo_tb.sv */
`timescale 1ns/1ps
`include "ooo_config.svh"

module ooo_tb import ooo_pkg::*; ();

    logic   clock;
    logic   reset;
    logic   instr_valid;
    instr_t instr;
    word_t  pc;
    logic   stall;
    logic   redirect;
    word_t  redirect_pc;
    logic   commit_valid;
    areg_t  commit_areg;
    word_t  commit_value;
    word_t  commit_pc;

    instr_t prog [0:255];                   // program image indexed by pc
    int     prog_len = 0;
    word_t  exp_pc [$];
    areg_t  exp_areg [$];
    word_t  exp_value [$];
    logic   exp_redirect [$];
    word_t  exp_target [$];
    integer seed = 13;
    int     errors = 0;
    int     checks = 0;
    int     commits_seen = 0;
    int     cycle_count = 0;
    int     cycle_limit = 200;
    logic   running = 1'b0;
    word_t  fetch_pc = '0;
    logic   fetch_run = 1'b0;               // values seen before the edge
    logic   fetch_taken = 1'b0;
    logic   fetch_redir = 1'b0;
    word_t  fetch_target = '0;

    ooo_top DUT (
        .clock, .reset, .instr_valid, .instr, .pc, .stall, .redirect, .redirect_pc,
        .commit_valid, .commit_areg, .commit_value, .commit_pc
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic instr_t r_type(opcode_t op, areg_t rd, areg_t rs1, areg_t rs2);
        return {op, rd, rs1, 3'b000, rs2, 1'b0};
    endfunction

    // li ignores rs1 and bne compares rs1 with rd
    function automatic instr_t i_type(opcode_t op, areg_t rd, areg_t rs1, int imm);
        logic [5:0] imm6;
        imm6 = imm[5:0];
        return {op, rd, rs1, 1'b0, imm6};
    endfunction

    task automatic emit(instr_t ins);
        prog[prog_len] = ins;
        prog_len++;
    endtask

    task automatic check_value(string what, word_t got, word_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    ////////////////////////////////////////
    // in-order interpreter
    ////////////////////////////////////////
    function automatic int run_reference();
        word_t  regs [`AREG_NUM];
        word_t  cur_pc;
        word_t  imm;
        word_t  v;
        instr_t ins;
        areg_t  rd;
        areg_t  rs1;
        areg_t  rs2;
        logic   taken;
        int     steps;
        for (int i = 0; i < `AREG_NUM; i++) begin
            regs[i] = '0;
        end
        cur_pc = '0;
        steps  = 0;
        while (cur_pc < prog_len && steps < 2000) begin
            ins = prog[cur_pc];
            rd  = ins[12:10];
            rs1 = ins[9:7];
            rs2 = ins[3:1];
            imm = {{(`XLEN - 6){ins[5]}}, ins[5:0]};
            case (ins[15:13])
                `OP_ADD: v = regs[rs1] + regs[rs2];
                `OP_SUB: v = regs[rs1] - regs[rs2];
                `OP_AND: v = regs[rs1] & regs[rs2];
                `OP_OR:  v = regs[rs1] | regs[rs2];
                `OP_XOR: v = regs[rs1] ^ regs[rs2];
                `OP_LI:  v = imm;
                default: v = '0;
            endcase
            exp_pc.push_back(cur_pc);
            steps++;
            if (ins[15:13] == `OP_BNE) begin
                taken = (regs[rs1] != regs[rd]);
                exp_areg.push_back('0);     // bne writes nothing
                exp_value.push_back('0);
                exp_redirect.push_back(taken);
                exp_target.push_back(cur_pc + imm);
                cur_pc = taken ? cur_pc + imm : cur_pc + 1'b1;
            end else begin
                if (rd != '0) begin
                    regs[rd] = v;
                end
                exp_areg.push_back(rd);
                exp_value.push_back((rd != '0) ? v : '0);
                exp_redirect.push_back(1'b0);
                exp_target.push_back('0);
                cur_pc = cur_pc + 1'b1;
            end
        end
        return steps;
    endfunction

    ////////////////////////////////////////
    // fetch model
    ////////////////////////////////////////
    always @(negedge clock) begin
        fetch_run    <= running && !reset;
        fetch_taken  <= instr_valid && !stall;
        fetch_redir  <= redirect;
        fetch_target <= redirect_pc;
    end

    always @(posedge clock) begin
        #2;
        if (!fetch_run) begin
            fetch_pc = '0;
        end else if (fetch_redir) begin
            fetch_pc = fetch_target;        // mispredicted bne
        end else if (fetch_taken) begin
            fetch_pc = fetch_pc + 1'b1;
        end
        instr_valid = fetch_run && (fetch_pc < prog_len);
        instr       = (fetch_pc < prog_len) ? prog[fetch_pc] : '0;
        pc          = fetch_pc;
    end

    // commit checker
    always @(negedge clock) begin : compare_commit
        logic  redir;
        word_t target;
        if (!reset && commit_valid) begin
            if (exp_pc.size() == 0) begin
                errors++;
                $display("commit of pc %h at %0t ns with nothing left to retire",
                         commit_pc, $time);
            end else begin
                redir  = exp_redirect.pop_front();
                target = exp_target.pop_front();
                check_value("commit pc", commit_pc, exp_pc.pop_front());
                check_value("commit register", word_t'(commit_areg),
                            word_t'(exp_areg.pop_front()));
                check_value("commit value", commit_value, exp_value.pop_front());
                check_value("redirect", word_t'(redirect), word_t'(redir));
                if (redir) begin
                    check_value("redirect pc", redirect_pc, target);
                    check_value("stall on redirect", word_t'(stall), word_t'(1'b1));
                end
                commits_seen++;
            end
        end
    end

    always @(posedge clock) begin
        if (running) begin
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("timeout after %0d cycles, %0d commits seen", cycle_count,
                         commits_seen);
                $display("errors: %0d, checks: %0d", errors + 1, checks);
                $display("Test failed");
                $finish;
            end
        end
    end

    task automatic run_program(string name);
        int n;
        running = 1'b0;
        reset   = 1'b1;
        repeat (8) @(posedge clock);
        #2;
        check_value("stall after reset", word_t'(stall), '0);
        check_value("redirect after reset", word_t'(redirect), '0);
        check_value("commit valid after reset", word_t'(commit_valid), '0);
        exp_pc.delete();
        exp_areg.delete();
        exp_value.delete();
        exp_redirect.delete();
        exp_target.delete();
        n            = run_reference();
        commits_seen = 0;
        cycle_count  = 0;
        cycle_limit  = 20 * n + 200;
        reset        = 1'b0;
        running      = 1'b1;
        wait (commits_seen >= n);
        repeat (10) @(posedge clock);       // catch stray commits
        #2;
        running = 1'b0;
        repeat (2) @(posedge clock);        // fetcher idle before next image
        #2;
        $display("%s: %0d of %0d instructions retired", name, commits_seen, n);
    endtask

    task automatic build_random(int count);
        opcode_t op;
        for (int k = 0; k < count; k++) begin
            op = opcode_t'($unsigned($random(seed)) % 7);
            if (op == `OP_BNE) begin
                emit(i_type(op, areg_t'($random(seed)), areg_t'($random(seed)),
                            1 + $unsigned($random(seed)) % 8));
            end else if (op == `OP_LI) begin
                emit(i_type(op, areg_t'($random(seed)), '0, $random(seed)));
            end else begin
                emit(r_type(op, areg_t'($random(seed)), areg_t'($random(seed)),
                            areg_t'($random(seed))));
            end
        end
    endtask

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        @(posedge clock);
        #2;
        emit(i_type(`OP_LI, 1, 0, 5));
        emit(i_type(`OP_LI, 2, 0, -3));
        emit(i_type(`OP_LI, 3, 0, 12));
        emit(i_type(`OP_LI, 4, 0, 9));
        emit(r_type(`OP_ADD, 5, 1, 2));
        emit(r_type(`OP_XOR, 6, 3, 4));
        emit(r_type(`OP_OR, 7, 1, 4));
        run_program("independent");
        prog_len = 0;
        emit(i_type(`OP_LI, 1, 0, 3));
        emit(r_type(`OP_ADD, 2, 1, 1));
        emit(r_type(`OP_ADD, 3, 2, 1));
        emit(r_type(`OP_SUB, 4, 3, 2));
        emit(r_type(`OP_AND, 5, 4, 3));
        emit(r_type(`OP_OR, 6, 5, 1));
        emit(r_type(`OP_XOR, 7, 6, 4));
        emit(r_type(`OP_SUB, 1, 7, 2));
        run_program("dependent");
        prog_len = 0;
        emit(i_type(`OP_LI, 0, 0, 5));
        emit(r_type(`OP_ADD, 1, 0, 0));
        emit(i_type(`OP_LI, 2, 0, 7));
        emit(r_type(`OP_OR, 0, 2, 2));
        emit(r_type(`OP_ADD, 3, 0, 2));
        emit(r_type(`OP_XOR, 4, 0, 2));
        run_program("register zero");
        prog_len = 0;
        emit(i_type(`OP_LI, 1, 0, 1));
        emit(i_type(`OP_BNE, 0, 1, 3));     // taken and skips two
        emit(i_type(`OP_LI, 2, 0, 9));
        emit(i_type(`OP_LI, 3, 0, 9));
        emit(i_type(`OP_LI, 4, 0, 4));
        emit(r_type(`OP_ADD, 5, 4, 1));
        emit(i_type(`OP_BNE, 1, 1, 2));     // not taken
        emit(i_type(`OP_LI, 6, 0, 2));
        emit(i_type(`OP_BNE, 0, 6, 2));
        emit(i_type(`OP_LI, 7, 0, 1));
        emit(r_type(`OP_ADD, 7, 6, 5));
        run_program("branch");
        prog_len = 0;
        emit(i_type(`OP_LI, 1, 0, 31));
        emit(r_type(`OP_ADD, 1, 1, 1));     // 62 passes
        emit(i_type(`OP_LI, 2, 0, 1));
        emit(r_type(`OP_SUB, 1, 1, 2));
        emit(r_type(`OP_ADD, 3, 3, 1));
        emit(r_type(`OP_XOR, 4, 4, 3));
        emit(i_type(`OP_BNE, 0, 1, -3));
        emit(r_type(`OP_OR, 5, 3, 4));
        run_program("loop");
        prog_len = 0;
        build_random(200);
        run_program("random");
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+.
ooo_pkg.sv
ooo_ifs.sv
decode_rename.sv
prf.sv
alu_execute.sv
result_commit.sv
retirement_rat.sv
ooo_top.sv
ooo_tb.sv
